/* include/proc_cfg.svh */
`ifndef PROC_CFG_SVH
`define PROC_CFG_SVH

// Data path and address width
`define PROC_XLEN 16

// Instruction memory, in words
`define PROC_IMEM_DEPTH 256
`define PROC_IMEM_AW 8

// First fetch address after reset
`define PROC_RESET_PC 16'h0000

`endif

/* rtl/procPkg.sv */
`include "proc_cfg.svh"

package procPkg;

    // Opcode field is instr[15:11]
    typedef enum logic [4:0] {
        opHalt = 5'b00000,
        opNop  = 5'b00001,
        opJ    = 5'b00100,
        opAddi = 5'b01000,
        opBeqz = 5'b01100,
        opBnez = 5'b01101,
        opSt   = 5'b10000,
        opLd   = 5'b10001,
        opLbi  = 5'b11000,
        opAlu  = 5'b11011
    } opcodeT;

    // ALU operation classes
    localparam logic [1:0] aluAdd = 2'd0;
    localparam logic [1:0] aluFunct = 2'd1;
    localparam logic [1:0] aluImm = 2'd2;

    typedef struct packed {
        logic [1:0] aluOp;
        logic       aluSrc;
        logic       memRead;
        logic       memWrite;
        logic       regWrite;
        logic       branch;
        logic       branchNe;
        logic       jump;
        logic       halt;
        logic       illegal;
    } ctrlT;

    typedef struct packed {
        logic [`PROC_XLEN-1:0] pc;
        logic [15:0]           instr;
        logic                  valid;
    } ifIdT;

    typedef struct packed {
        logic [`PROC_XLEN-1:0] pc;
        logic [`PROC_XLEN-1:0] rsData;
        logic [`PROC_XLEN-1:0] rtData;
        logic [`PROC_XLEN-1:0] imm;
        logic [1:0]            funct;
        logic [2:0]            rs;
        logic [2:0]            rt;
        logic [2:0]            rd;
        logic                  rsUsed;
        logic                  rtUsed;
        ctrlT                  ctrl;
        logic                  valid;
    } idExT;

    typedef struct packed {
        logic [`PROC_XLEN-1:0] aluRes;
        logic [`PROC_XLEN-1:0] storeData;
        logic [2:0]            rd;
        ctrlT                  ctrl;
        logic                  valid;
    } exMemT;

    typedef struct packed {
        logic [`PROC_XLEN-1:0] result;
        logic [2:0]            rd;
        logic                  regWrite;
        logic                  halt;
        logic                  illegal;
        logic                  valid;
    } memWbT;

    typedef enum logic [1:0] {
        none      = 2'd0,
        fromExMem = 2'd1,
        fromMemWb = 2'd2
    } fwdSelT;

    // Register sources an opcode reads, as {rs, rt}
    // ST reads its data register through the rt field
    function automatic logic [1:0] srcUse(input logic [4:0] op);
        case (op)
            opAlu, opSt: srcUse = 2'b11;
            opAddi, opLd, opBeqz, opBnez: srcUse = 2'b10;
            default: srcUse = 2'b00;
        endcase
    endfunction

endpackage

/* rtl/pipeCtrlIf.sv */
`timescale 1ns/10ps

interface pipeCtrlIf;
    logic            stallFront;
    logic            bubbleEx;
    logic            stallAll;
    logic            flushFront;
    procPkg::fwdSelT fwdA;
    procPkg::fwdSelT fwdB;
    logic            memBusy;

    modport hazard (
        output stallFront, bubbleEx, stallAll, fwdA, fwdB,
        input  memBusy
    );
    modport fetchSide (input stallFront, stallAll);
    modport exSide (input fwdA, fwdB, output flushFront);
    modport memSide (output memBusy);
    modport regSide (input stallFront, bubbleEx, stallAll, flushFront);
endinterface

/* rtl/pipeReg.sv */
`timescale 1ns/10ps

module pipeReg #(
    parameter type payloadT = logic
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    hold,
    input  logic    bubble,
    input  payloadT d,
    output payloadT q
);

    // Hold wins over bubble so a stalled stage keeps its instruction
    always_ff @(posedge clk) begin
        if (rst) begin
            q <= '0;
        end else if (!hold) begin
            if (bubble) begin
                q <= '0;
            end else begin
                q <= d;
            end
        end
    end

endmodule

/* rtl/fetch.sv */
`timescale 1ns/10ps
`include "proc_cfg.svh"

module fetch (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start,
    input  logic                  progWe,
    input  logic [`PROC_XLEN-1:0] progAddr,
    input  logic [`PROC_XLEN-1:0] progData,
    input  logic                  redirect,
    input  logic [`PROC_XLEN-1:0] redirectPc,
    input  logic                  stopped,
    pipeCtrlIf.fetchSide          ctl,
    output procPkg::ifIdT         ifId
);

    logic [`PROC_XLEN-1:0] pc;
    logic                  running;
    logic [15:0]           imem [`PROC_IMEM_DEPTH];

    // Program load port
    always_ff @(posedge clk) begin
        if (progWe) begin
            imem[progAddr[`PROC_IMEM_AW-1:0]] <= progData;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= `PROC_RESET_PC;
            running <= 1'b0;
        end else begin
            if (start) begin
                running <= 1'b1;
            end
            // A taken branch still in execute redirects once the stall clears
            if (!ctl.stallAll) begin
                if (redirect) begin
                    pc <= redirectPc;
                end else if (running && !stopped && !ctl.stallFront) begin
                    pc <= pc + `PROC_XLEN'd1;
                end
            end
        end
    end

    always_comb begin
        ifId.pc = pc;
        ifId.instr = imem[pc[`PROC_IMEM_AW-1:0]];
        ifId.valid = running && !stopped;
    end

endmodule

/* rtl/decode.sv */
`timescale 1ns/10ps
`include "proc_cfg.svh"

module decode (
    input  logic                  clk,
    input  logic                  rst,
    input  procPkg::ifIdT         ifId,
    input  logic                  wbWe,
    input  logic [2:0]            wbAddr,
    input  logic [`PROC_XLEN-1:0] wbData,
    output procPkg::idExT         idEx
);

    logic [`PROC_XLEN-1:0] regs [8];
    logic [4:0]            op;
    logic [2:0]            rs;
    logic [2:0]            rt;
    logic [2:0]            rd;
    logic [1:0]            srcMask;
    logic [`PROC_XLEN-1:0] imm;
    procPkg::ctrlT         ctrl;

    assign op = ifId.instr[15:11];
    assign rs = ifId.instr[10:8];
    assign rt = ifId.instr[7:5];
    assign srcMask = procPkg::srcUse(op);

    // Register file, r0 is a normal register
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (wbWe) begin
            regs[wbAddr] <= wbData;
        end
    end

    always_comb begin
        ctrl = '0;
        case (op)
            procPkg::opAlu: begin
                ctrl.aluOp = procPkg::aluFunct;
                ctrl.regWrite = 1'b1;
            end
            procPkg::opAddi: begin
                ctrl.aluSrc = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            procPkg::opLbi: begin
                ctrl.aluOp = procPkg::aluImm;
                ctrl.aluSrc = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            procPkg::opLd: begin
                ctrl.aluSrc = 1'b1;
                ctrl.memRead = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            procPkg::opSt: begin
                ctrl.aluSrc = 1'b1;
                ctrl.memWrite = 1'b1;
            end
            procPkg::opBeqz: ctrl.branch = 1'b1;
            procPkg::opBnez: begin
                ctrl.branch = 1'b1;
                ctrl.branchNe = 1'b1;
            end
            procPkg::opJ: ctrl.jump = 1'b1;
            procPkg::opHalt: ctrl.halt = 1'b1;
            procPkg::opNop: ;
            default: ctrl.illegal = 1'b1;
        endcase
        // Empty slots carry no control at all
        if (!ifId.valid) begin
            ctrl = '0;
        end
    end

    // Immediate and destination by format
    always_comb begin
        imm = {{(`PROC_XLEN-5){ifId.instr[4]}}, ifId.instr[4:0]};
        rd = rt;
        case (op)
            procPkg::opAlu: rd = ifId.instr[4:2];
            procPkg::opLbi: begin
                imm = {{(`PROC_XLEN-8){1'b0}}, ifId.instr[7:0]};
                rd = rs;
            end
            procPkg::opBeqz, procPkg::opBnez: begin
                imm = {{(`PROC_XLEN-8){ifId.instr[7]}}, ifId.instr[7:0]};
            end
            procPkg::opJ: imm = {{(`PROC_XLEN-11){ifId.instr[10]}}, ifId.instr[10:0]};
            default: ;
        endcase
    end

    always_comb begin
        idEx.pc = ifId.pc;
        // Same-cycle writeback is bypassed to the reads
        idEx.rsData = (wbWe && wbAddr == rs) ? wbData : regs[rs];
        idEx.rtData = (wbWe && wbAddr == rt) ? wbData : regs[rt];
        idEx.imm = imm;
        idEx.funct = ifId.instr[1:0];
        idEx.rs = rs;
        idEx.rt = rt;
        idEx.rd = rd;
        idEx.rsUsed = srcMask[1];
        idEx.rtUsed = srcMask[0];
        idEx.ctrl = ctrl;
        idEx.valid = ifId.valid;
    end

endmodule

/* rtl/execute.sv */
`timescale 1ns/10ps
`include "proc_cfg.svh"

module execute (
    input  procPkg::idExT         idEx,
    input  logic [`PROC_XLEN-1:0] exMemFwd,
    input  logic [`PROC_XLEN-1:0] memWbFwd,
    pipeCtrlIf.exSide             ctl,
    output procPkg::exMemT        exMem,
    output logic                  redirect,
    output logic [`PROC_XLEN-1:0] redirectPc
);

    logic [`PROC_XLEN-1:0] opA;
    logic [`PROC_XLEN-1:0] opB;
    logic [`PROC_XLEN-1:0] aluB;
    logic [`PROC_XLEN-1:0] aluRes;
    logic                  taken;
    logic                  spin;

    function automatic logic [`PROC_XLEN-1:0] pickOperand(
        input procPkg::fwdSelT       sel,
        input logic [`PROC_XLEN-1:0] regVal,
        input logic [`PROC_XLEN-1:0] exVal,
        input logic [`PROC_XLEN-1:0] wbVal
    );
        case (sel)
            procPkg::fromExMem: return exVal;
            procPkg::fromMemWb: return wbVal;
            default: return regVal;
        endcase
    endfunction

    assign opA = pickOperand(ctl.fwdA, idEx.rsData, exMemFwd, memWbFwd);
    assign opB = pickOperand(ctl.fwdB, idEx.rtData, exMemFwd, memWbFwd);
    assign aluB = idEx.ctrl.aluSrc ? idEx.imm : opB;

    always_comb begin
        case (idEx.ctrl.aluOp)
            procPkg::aluFunct: begin
                case (idEx.funct)
                    2'b00: aluRes = opA + aluB;
                    2'b01: aluRes = opA - aluB;
                    2'b10: aluRes = opA ^ aluB;
                    default: aluRes = opA & aluB;
                endcase
            end
            procPkg::aluImm: aluRes = idEx.imm;
            default: aluRes = opA + aluB;
        endcase
    end

    // Branch tests the forwarded rs
    assign taken = idEx.valid && (idEx.ctrl.jump ||
        (idEx.ctrl.branch && ((opA == '0) != idEx.ctrl.branchNe)));

    // HALT and illegal refetch themselves until the top flags stop fetch,
    // so nothing younger ever reaches memory
    assign spin = idEx.valid && (idEx.ctrl.halt || idEx.ctrl.illegal);

    assign redirect = taken || spin;
    assign redirectPc = spin ? idEx.pc : idEx.pc + `PROC_XLEN'd1 + idEx.imm;
    assign ctl.flushFront = redirect;

    always_comb begin
        exMem.aluRes = aluRes;
        exMem.storeData = opB;
        exMem.rd = idEx.rd;
        exMem.ctrl = idEx.ctrl;
        exMem.valid = idEx.valid;
    end

endmodule

/* rtl/memStage.sv */
`timescale 1ns/10ps
`include "proc_cfg.svh"

module memStage (
    input  logic                  clk,
    input  logic                  rst,
    input  procPkg::exMemT        exMem,
    pipeCtrlIf.memSide            ctl,
    output logic                  cyc,
    output logic                  stb,
    output logic                  we,
    output logic [`PROC_XLEN-1:0] adr,
    output logic [`PROC_XLEN-1:0] datWr,
    input  logic [`PROC_XLEN-1:0] datRd,
    input  logic                  ack,
    output procPkg::memWbT        memWb
);

    typedef enum logic {
        idle,
        waitAck
    } stateT;

    stateT state;
    logic  memOp;

    assign memOp = exMem.valid && (exMem.ctrl.memRead || exMem.ctrl.memWrite);

    // One cycle per LD or ST; back in idle the next instruction is already here
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
        end else begin
            case (state)
                idle: begin
                    if (memOp) begin
                        state <= waitAck;
                    end
                end
                default: begin
                    if (ack) begin
                        state <= idle;
                    end
                end
            endcase
        end
    end

    // Bus payload stays fixed for the whole cycle
    always_ff @(posedge clk) begin
        if (state == idle && memOp) begin
            we <= exMem.ctrl.memWrite;
            adr <= exMem.aluRes;
            datWr <= exMem.storeData;
        end
    end

    assign cyc = (state == waitAck);
    assign stb = cyc;
    assign ctl.memBusy = (state == idle) ? memOp : !ack;

    // MEM/WB only loads on the ack cycle, which samples datRd there
    always_comb begin
        memWb.result = exMem.ctrl.memRead ? datRd : exMem.aluRes;
        memWb.rd = exMem.rd;
        memWb.regWrite = exMem.ctrl.regWrite;
        memWb.halt = exMem.ctrl.halt;
        memWb.illegal = exMem.ctrl.illegal;
        memWb.valid = exMem.valid;
    end

endmodule

/* rtl/hazardUnit.sv */
`timescale 1ns/10ps

module hazardUnit (
    input procPkg::idExT  idEx,
    input procPkg::ifIdT  ifId,
    input procPkg::exMemT exMem,
    input procPkg::memWbT memWb,
    pipeCtrlIf.hazard     ctl
);

    logic [1:0] srcMask;
    logic       loadUse;
    logic       exMemOk;
    logic       memWbOk;

    // EX/MEM first, then MEM/WB
    function automatic procPkg::fwdSelT fwdFor(
        input logic       used,
        input logic [2:0] src,
        input logic       exOk,
        input logic [2:0] exRd,
        input logic       wbOk,
        input logic [2:0] wbRd
    );
        if (used && exOk && exRd == src) begin
            return procPkg::fromExMem;
        end
        if (used && wbOk && wbRd == src) begin
            return procPkg::fromMemWb;
        end
        return procPkg::none;
    endfunction

    assign srcMask = procPkg::srcUse(ifId.instr[15:11]);

    // Load in execute feeding the instruction being decoded
    assign loadUse = idEx.valid && idEx.ctrl.memRead && ifId.valid &&
        ((srcMask[1] && ifId.instr[10:8] == idEx.rd) ||
         (srcMask[0] && ifId.instr[7:5] == idEx.rd));

    // A load in EX/MEM has only its address so far
    assign exMemOk = exMem.valid && exMem.ctrl.regWrite && !exMem.ctrl.memRead;
    assign memWbOk = memWb.valid && memWb.regWrite;

    assign ctl.fwdA = fwdFor(idEx.rsUsed, idEx.rs, exMemOk, exMem.rd, memWbOk, memWb.rd);
    assign ctl.fwdB = fwdFor(idEx.rtUsed, idEx.rt, exMemOk, exMem.rd, memWbOk, memWb.rd);

    assign ctl.stallFront = loadUse;
    assign ctl.bubbleEx = loadUse;
    assign ctl.stallAll = ctl.memBusy;

endmodule

/* rtl/proc.sv */
`timescale 1ns/10ps
`include "proc_cfg.svh"

module proc (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start,
    input  logic                  progWe,
    input  logic [`PROC_XLEN-1:0] progAddr,
    input  logic [`PROC_XLEN-1:0] progData,
    output logic                  cyc,
    output logic                  stb,
    output logic                  we,
    output logic [`PROC_XLEN-1:0] adr,
    output logic [`PROC_XLEN-1:0] datWr,
    input  logic [`PROC_XLEN-1:0] datRd,
    input  logic                  ack,
    output logic                  halted,
    output logic                  err
);

    pipeCtrlIf ctl ();

    procPkg::ifIdT         ifIdD;
    procPkg::ifIdT         ifIdQ;
    procPkg::idExT         idExD;
    procPkg::idExT         idExQ;
    procPkg::exMemT        exMemD;
    procPkg::exMemT        exMemQ;
    procPkg::memWbT        memWbD;
    procPkg::memWbT        memWbQ;
    logic                  redirect;
    logic [`PROC_XLEN-1:0] redirectPc;
    logic                  wbWe;
    logic                  stopped;

    assign stopped = halted || err;

    fetch fetch0 (
        .clk(clk), .rst(rst), .start(start),
        .progWe(progWe), .progAddr(progAddr), .progData(progData),
        .redirect(redirect), .redirectPc(redirectPc), .stopped(stopped),
        .ctl(ctl.fetchSide), .ifId(ifIdD)
    );

    pipeReg #(.payloadT(procPkg::ifIdT)) ifIdReg (
        .clk(clk), .rst(rst),
        .hold(ctl.stallAll || ctl.stallFront), .bubble(ctl.flushFront),
        .d(ifIdD), .q(ifIdQ)
    );

    decode decode0 (
        .clk(clk), .rst(rst), .ifId(ifIdQ),
        .wbWe(wbWe), .wbAddr(memWbQ.rd), .wbData(memWbQ.result),
        .idEx(idExD)
    );

    pipeReg #(.payloadT(procPkg::idExT)) idExReg (
        .clk(clk), .rst(rst),
        .hold(ctl.stallAll), .bubble(ctl.bubbleEx || ctl.flushFront),
        .d(idExD), .q(idExQ)
    );

    execute exec0 (
        .idEx(idExQ), .exMemFwd(exMemQ.aluRes), .memWbFwd(memWbQ.result),
        .ctl(ctl.exSide), .exMem(exMemD),
        .redirect(redirect), .redirectPc(redirectPc)
    );

    pipeReg #(.payloadT(procPkg::exMemT)) exMemReg (
        .clk(clk), .rst(rst), .hold(ctl.stallAll), .bubble(1'b0),
        .d(exMemD), .q(exMemQ)
    );

    memStage mem0 (
        .clk(clk), .rst(rst), .exMem(exMemQ), .ctl(ctl.memSide),
        .cyc(cyc), .stb(stb), .we(we), .adr(adr), .datWr(datWr),
        .datRd(datRd), .ack(ack), .memWb(memWbD)
    );

    pipeReg #(.payloadT(procPkg::memWbT)) memWbReg (
        .clk(clk), .rst(rst), .hold(ctl.stallAll), .bubble(1'b0),
        .d(memWbD), .q(memWbQ)
    );

    hazardUnit hazard0 (
        .idEx(idExQ), .ifId(ifIdQ), .exMem(exMemQ), .memWb(memWbQ),
        .ctl(ctl.hazard)
    );

    // Writeback
    assign wbWe = memWbQ.valid && memWbQ.regWrite;

    // Sticky status, set as HALT or a bad opcode leaves writeback
    always_ff @(posedge clk) begin
        if (rst) begin
            halted <= 1'b0;
            err <= 1'b0;
        end else if (memWbQ.valid) begin
            if (memWbQ.halt) begin
                halted <= 1'b1;
            end
            if (memWbQ.illegal) begin
                err <= 1'b1;
            end
        end
    end

endmodule

/* tests/procTb.sv */
`timescale 1ns/10ps
`include "proc_cfg.svh"

module procTb;

    localparam int patDepth = 128;
    localparam logic [15:0] endMark = 16'hFFFF;
    localparam int flagTimeout = 2000;

    logic                  clk;
    logic                  rst;
    logic                  start;
    logic                  progWe;
    logic [`PROC_XLEN-1:0] progAddr;
    logic [`PROC_XLEN-1:0] progData;
    logic                  cyc;
    logic                  stb;
    logic                  we;
    logic [`PROC_XLEN-1:0] adr;
    logic [`PROC_XLEN-1:0] datWr;
    logic [`PROC_XLEN-1:0] datRd;
    logic                  ack;
    logic                  halted;
    logic                  err;

    logic [15:0]           pat [patDepth];
    logic [`PROC_XLEN-1:0] mem [256];
    int                    writeCount [256];
    logic [`PROC_XLEN-1:0] expAddr [32];
    logic [`PROC_XLEN-1:0] expData [32];
    int                    expCount;
    integer                seed = 31797;

    proc proc_i (
        .clk(clk), .rst(rst), .start(start),
        .progWe(progWe), .progAddr(progAddr), .progData(progData),
        .cyc(cyc), .stb(stb), .we(we), .adr(adr), .datWr(datWr),
        .datRd(datRd), .ack(ack), .halted(halted), .err(err)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Inputs change 2 ns after the rising edge
    task automatic tick();
        @(posedge clk);
        #2;
    endtask

    task automatic failWith(input string what);
        $display("%0s", what);
        $display("TEST RESULT: FAIL");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic checkValue(input string name, input logic [15:0] actual,
                              input logic [15:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] %0s: got %h, expected %h", name, actual, expected);
            $display("TEST RESULT: FAIL");
            $fatal(1, "Simulation stopped");
        end
    endtask

    function automatic logic isExpected(input logic [`PROC_XLEN-1:0] a);
        logic hit;
        hit = 1'b0;
        for (int i = 0; i < expCount; i++) begin
            if (expAddr[i] == a) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    // Slave side of one finished transfer
    task automatic serveTransfer(input logic [`PROC_XLEN-1:0] a, input logic w,
                                 input logic [`PROC_XLEN-1:0] d);
        if (w) begin
            if (!isExpected(a)) begin
                failWith($sformatf("Store to address %h is not in the expected list", a));
            end
            if (writeCount[a[7:0]] != 0) begin
                failWith($sformatf("Address %h was stored to more than once", a));
            end
            mem[a[7:0]] = d;
            writeCount[a[7:0]]++;
        end else begin
            datRd = mem[a[7:0]];
        end
    endtask

    // Wishbone slave memory with 0 to 3 wait cycles
    initial begin
        logic [`PROC_XLEN-1:0] busAdr;
        logic                  busWe;
        logic [`PROC_XLEN-1:0] busDat;
        logic                  active;
        int                    waitLeft;
        ack = 1'b0;
        datRd = '0;
        active = 1'b0;
        waitLeft = 0;
        forever begin
            tick();
            if (rst) begin
                ack = 1'b0;
                active = 1'b0;
            end else if (ack) begin
                ack = 1'b0;
                checkValue("cyc after ack", cyc, 1'b0);
                checkValue("stb after ack", stb, 1'b0);
            end else if (active || (cyc && stb)) begin
                if (!active) begin
                    active = 1'b1;
                    busAdr = adr;
                    busWe = we;
                    busDat = datWr;
                    waitLeft = $unsigned($random(seed)) % 4;
                end else begin
                    // Master must not change the request while waiting
                    checkValue("cyc", cyc, 1'b1);
                    checkValue("stb", stb, 1'b1);
                    checkValue("adr", adr, busAdr);
                    checkValue("we", we, busWe);
                    checkValue("datWr", datWr, busDat);
                end
                if (waitLeft == 0) begin
                    serveTransfer(busAdr, busWe, busDat);
                    ack = 1'b1;
                    active = 1'b0;
                end else begin
                    waitLeft--;
                end
            end
        end
    end

    // Reset, load one program block, run it and check memory against its pairs
    task automatic runProgram(inout integer idx, input logic expectErr);
        int loadLen;
        int waited;
        for (int i = 0; i < 256; i++) begin
            mem[i] = 16'h5A3C ^ (i * 16'h0101);
            writeCount[i] = 0;
        end
        rst = 1'b1;
        start = 1'b0;
        repeat (5) tick();
        rst = 1'b0;

        loadLen = 0;
        while (idx < patDepth && pat[idx] !== endMark) begin
            progWe = 1'b1;
            progAddr = loadLen;
            progData = pat[idx];
            tick();
            loadLen++;
            idx++;
        end
        progWe = 1'b0;
        if (idx >= patDepth) begin
            failWith("Program block in the patterns file has no end marker");
        end
        idx++;

        expCount = 0;
        while (idx + 2 < patDepth && expCount < 32 && pat[idx] !== endMark) begin
            expAddr[expCount] = pat[idx];
            expData[expCount] = pat[idx + 1];
            expCount++;
            idx += 2;
        end
        if (pat[idx] !== endMark) begin
            failWith("Expected block in the patterns file has no end marker");
        end
        idx++;

        start = 1'b1;
        tick();
        start = 1'b0;

        waited = 0;
        while (!halted && !err && waited < flagTimeout) begin
            tick();
            waited++;
        end
        if (!halted && !err) begin
            failWith("Timeout: neither halted nor err rose after the program started");
        end
        checkValue("halted", halted, !expectErr);
        checkValue("err", err, expectErr);

        // Stopped core stays off the bus
        repeat (20) begin
            tick();
            if (cyc) begin
                failWith("A Wishbone cycle started after the core had stopped");
            end
        end

        for (int i = 0; i < expCount; i++) begin
            checkValue($sformatf("store count at %h", expAddr[i]),
                       writeCount[expAddr[i][7:0]], 16'd1);
            checkValue($sformatf("mem[%h]", expAddr[i]), mem[expAddr[i][7:0]], expData[i]);
        end
    endtask

    initial begin
        integer idx;
        rst = 1'b1;
        start = 1'b0;
        progWe = 1'b0;
        progAddr = '0;
        progData = '0;
        expCount = 0;
        $readmemh("tests/proc_patterns.hex", pat);
        if ($isunknown(pat[0])) begin
            failWith("Patterns file tests/proc_patterns.hex could not be read");
        end
        idx = 0;
        // ALU, forwarding, load-use, branches, random waits, HALT
        runProgram(idx, 1'b0);
        // Illegal opcode after one store
        runProgram(idx, 1'b1);
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

/* tests/proc_patterns.hex */
// Program words up to FFFF, then expected address and data pairs up to FFFF
// Run 1 exercises ALU, forwarding, branches and HALT; run 2 stops on an illegal opcode
C720 C135 4147 D94C   // Base r7, LBI r1, ADDI r2, ADD r3
DB31 DC77 DD5A        // SUB r4, AND r5, XOR r6
8740 8761 8782 87A3 87C4
413D 8725             // ADDI with negative immediate, store data forwarded
8F41 4261 8766        // Load-use into ADDI
8F83 8787             // Load-use into store data
C000 6002 8728 8729   // BEQZ taken over two stores
6805 87CA             // BNEZ not taken
2002 872B 872C        // J over two stores
40A1 6D01 872D 87AE   // BNEZ taken on forwarded r5
0000
FFFF
0020 003C
0021 0071
0022 003C
0023 0030
0024 000C
0025 0032
0026 0072
0027 0030
002A 000C
002E 0001
FFFF
C740 C111 8720 1000 8721 8722 0000
FFFF
0040 0011
FFFF

/* src.f */
+incdir+include
rtl/procPkg.sv
rtl/pipeCtrlIf.sv
rtl/pipeReg.sv
rtl/fetch.sv
rtl/decode.sv
rtl/execute.sv
rtl/memStage.sv
rtl/hazardUnit.sv
rtl/proc.sv
tests/procTb.sv
